//--- design/rxbuf_cfg.svh
/*
 * Receive buffer sizing
 * Widths shared by the package and the RTL
 */
`ifndef RXBUF_CFG_SVH
`define RXBUF_CFG_SVH

// ========================================
// Datapath
// ========================================

// Byte width on the receive side
`define RXBUF_DATA_WIDTH 8

// FIFO address bits for 16 entries
// Never below 2 because the quadrant logic reads the top two pointer bits
`define RXBUF_ADDR_WIDTH 4

// ========================================
// Counters
// ========================================

// Statistics and overflow counters, all saturating
`define RXBUF_CNT_WIDTH 16

`endif

//--- design/rxBufPkg.sv
/*
 * Receive buffer types
 * Entry kinds, controller states, byte and FIFO word layouts
 */
`include "rxbuf_cfg.svh"

package rxBufPkg;

    // Tag stored with each FIFO word
    typedef enum logic [1:0] {
        KindData  = 2'd0,
        KindEnd   = 2'd1,
        KindAbort = 2'd2
    } entryKind_t;

    // Write side controller states
    typedef enum logic [1:0] {
        StIdle    = 2'd0,
        StRecv    = 2'd1,
        StDiscard = 2'd2
    } ctrlState_t;

    // One FIFO word and also the read port
    typedef struct packed {
        entryKind_t                   kind;
        logic [`RXBUF_DATA_WIDTH-1:0] data;
    } fifoEntry_t;

    // Incoming byte with its frame marks
    typedef struct packed {
        logic                         valid;
        logic                         sof;
        logic                         eof;
        logic [`RXBUF_DATA_WIDTH-1:0] data;
    } rxByte_t;

endpackage

//--- design/grayCounter.sv
/*
 * Gray pointer counter
 * Binary count plus a registered Gray copy so only one
 * output bit moves per step as seen from the other clock
 */
`timescale 1ns/1ps

module grayCounter #(
    parameter int CountWidth = 4
) (
    input  logic                  clk,
    input  logic                  clear,
    input  logic                  enable,
    output logic [CountWidth-1:0] count
);

    // Binary shadow of the pointer
    logic [CountWidth-1:0] binCount;
    logic [CountWidth-1:0] binNext;

    // Value the pointer steps to
    assign binNext = binCount + 1'b1;

    // Both copies start at 1 after clear
    // Gray of 1 is 1 so they agree from the start
    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            binCount <= CountWidth'(1);
            count    <= CountWidth'(1);
        end else if (enable) begin
            binCount <= binNext;
            // Binary to Gray of the next value
            count    <= binNext ^ (binNext >> 1);
        end
    end

endmodule

//--- design/asyncFifo.sv
/*
 * Dual-clock entry FIFO
 * Gray pointers with a quadrant direction latch
 * Full and empty are preset asynchronously and released on their own clocks
 */
`timescale 1ns/1ps
`include "rxbuf_cfg.svh"

module asyncFifo import rxBufPkg::*; (
    input  logic       WClk,
    input  logic       RClk,
    input  logic       PresetEmpty,
    // Write port
    input  logic       push,
    input  fifoEntry_t pushEntry,
    output logic       full,
    // Read port
    input  logic       readEn,
    output logic       empty,
    output logic       pop,
    output fifoEntry_t rdEntry
);

    localparam int AddrWidth = `RXBUF_ADDR_WIDTH;
    localparam int Depth     = 1 << AddrWidth;

    fifoEntry_t           mem [Depth];
    logic [AddrWidth-1:0] wrPtr;
    logic [AddrWidth-1:0] rdPtr;
    logic                 ptrEqual;
    logic                 setStatus;
    logic                 rstStatus;
    // Direction latch, high while the writer closes on the reader
    logic                 dirStatus;
    logic                 fullPreset;
    logic                 emptyPreset;

    // ========================================
    // Storage
    // ========================================

    // Push is already qualified by full in the controller
    always_ff @(posedge WClk) begin
        if (push) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    // First-word fall-through head
    assign rdEntry = mem[rdPtr];

    // Read strobe
    assign pop = readEn & ~empty;

    // ========================================
    // Pointers
    // ========================================

    grayCounter #(
        .CountWidth(AddrWidth)
    ) u_wrPtr (
        .clk   (WClk),
        .clear (PresetEmpty),
        .enable(push),
        .count (wrPtr)
    );

    grayCounter #(
        .CountWidth(AddrWidth)
    ) u_rdPtr (
        .clk   (RClk),
        .clear (PresetEmpty),
        .enable(pop),
        .count (rdPtr)
    );

    assign ptrEqual = (wrPtr == rdPtr);

    // Writer one quadrant behind the reader
    assign setStatus = (wrPtr[AddrWidth-2] ~^ rdPtr[AddrWidth-1]) &
                       (wrPtr[AddrWidth-1] ^  rdPtr[AddrWidth-2]);

    // Reader one quadrant behind the writer
    assign rstStatus = (wrPtr[AddrWidth-2] ^  rdPtr[AddrWidth-1]) &
                       (wrPtr[AddrWidth-1] ~^ rdPtr[AddrWidth-2]);

    // Direction latch with clear priority
    always_latch begin
        if (rstStatus || PresetEmpty) begin
            dirStatus <= 1'b0;
        end else if (setStatus) begin
            dirStatus <= 1'b1;
        end
    end

    // ========================================
    // Status flags
    // ========================================

    // Equal pointers mean full or empty depending on direction
    assign fullPreset  = dirStatus & ptrEqual;
    assign emptyPreset = ~dirStatus & ptrEqual;

    // Full set at once, dropped on the next WClk edge
    always_ff @(posedge WClk or posedge fullPreset or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            full <= 1'b0;
        end else if (fullPreset) begin
            full <= 1'b1;
        end else begin
            full <= 1'b0;
        end
    end

    // Empty set at once, dropped on the next RClk edge
    always_ff @(posedge RClk or posedge emptyPreset or posedge PresetEmpty) begin
        if (PresetEmpty || emptyPreset) begin
            empty <= 1'b1;
        end else begin
            empty <= 1'b0;
        end
    end

endmodule

//--- design/rxFrameCtrl.sv
/*
 * Receive frame controller
 * Tags incoming bytes as FIFO entries, drops the rest of a frame on
 * overflow and queues an abort marker in its place
 */
`timescale 1ns/1ps
`include "rxbuf_cfg.svh"

module rxFrameCtrl import rxBufPkg::*; (
    input  logic                        WClk,
    input  logic                        PresetEmpty,
    input  rxByte_t                     rxIn,
    input  logic                        full,
    output logic                        push,
    output fifoEntry_t                  pushEntry,
    output logic [`RXBUF_CNT_WIDTH-1:0] overflowCount
);

    ctrlState_t state;
    ctrlState_t stateNext;
    // Marker owed to the reader for a cut frame
    logic       abortPending;
    logic       abortNext;
    // Byte lost this cycle
    logic       dropByte;

    // ========================================
    // Next state and push decode
    // ========================================

    always_comb begin
        stateNext = state;
        abortNext = abortPending;
        push      = 1'b0;
        dropByte  = 1'b0;
        pushEntry = '{kind: KindData, data: rxIn.data};

        if (abortPending) begin
            // Marker goes out on the first free slot
            if (!full) begin
                push           = 1'b1;
                pushEntry.kind = KindAbort;
                pushEntry.data = '0;
                abortNext      = 1'b0;
            end
            // Byte of this edge is lost either way
            if (rxIn.valid) begin
                if (state == StDiscard && rxIn.eof) begin
                    // End of the cut frame is not counted
                    stateNext = StIdle;
                end else begin
                    dropByte = 1'b1;
                end
            end
        end else begin
            case (state)
                StIdle: begin
                    // Only a sof opens a frame
                    if (rxIn.valid && rxIn.sof) begin
                        if (full) begin
                            // Nothing stored yet so no marker
                            dropByte = 1'b1;
                            if (!rxIn.eof) begin
                                stateNext = StDiscard;
                            end
                        end else begin
                            push           = 1'b1;
                            pushEntry.kind = rxIn.eof ? KindEnd : KindData;
                            stateNext      = rxIn.eof ? StIdle : StRecv;
                        end
                    end
                end
                StRecv: begin
                    if (rxIn.valid) begin
                        if (full) begin
                            // Part of the frame is in the FIFO
                            dropByte  = 1'b1;
                            abortNext = 1'b1;
                            stateNext = rxIn.eof ? StIdle : StDiscard;
                        end else begin
                            push           = 1'b1;
                            pushEntry.kind = rxIn.eof ? KindEnd : KindData;
                            if (rxIn.eof) begin
                                stateNext = StIdle;
                            end
                        end
                    end
                end
                StDiscard: begin
                    // Swallow until the frame ends
                    if (rxIn.valid) begin
                        if (rxIn.eof) begin
                            stateNext = StIdle;
                        end else begin
                            dropByte = 1'b1;
                        end
                    end
                end
                default: stateNext = StIdle;
            endcase
        end
    end

    // ========================================
    // Registers
    // ========================================

    always_ff @(posedge WClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            state         <= StIdle;
            abortPending  <= 1'b0;
            overflowCount <= '0;
        end else begin
            state        <= stateNext;
            abortPending <= abortNext;
            // Saturating drop count
            if (dropByte && overflowCount != '1) begin
                overflowCount <= overflowCount + 1'b1;
            end
        end
    end

endmodule

//--- design/frameStats.sv
/*
 * Read side frame statistics
 * Counts good and aborted frames as their last entry is popped
 */
`timescale 1ns/1ps
`include "rxbuf_cfg.svh"

module frameStats import rxBufPkg::*; (
    input  logic                        RClk,
    input  logic                        PresetEmpty,
    input  logic                        pop,
    input  fifoEntry_t                  rdEntry,
    output logic [`RXBUF_CNT_WIDTH-1:0] goodFrames,
    output logic [`RXBUF_CNT_WIDTH-1:0] abortFrames
);

    logic goodHit;
    logic abortHit;

    // Frame closers taken this cycle
    assign goodHit  = pop && (rdEntry.kind == KindEnd);
    assign abortHit = pop && (rdEntry.kind == KindAbort);

    // ========================================
    // Counters
    // ========================================

    // Good frames, saturating
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            goodFrames <= '0;
        end else if (goodHit && goodFrames != '1) begin
            goodFrames <= goodFrames + 1'b1;
        end
    end

    // Aborted frames, saturating
    always_ff @(posedge RClk or posedge PresetEmpty) begin
        if (PresetEmpty) begin
            abortFrames <= '0;
        end else if (abortHit && abortFrames != '1) begin
            abortFrames <= abortFrames + 1'b1;
        end
    end

endmodule

//--- design/rxFrameBuffer.sv
/*
 * Receive frame buffer top
 * Write side controller, dual-clock FIFO and read side statistics
 */
`timescale 1ns/1ps
`include "rxbuf_cfg.svh"

module rxFrameBuffer import rxBufPkg::*; (
    input  logic                        WClk,
    input  logic                        RClk,
    input  logic                        PresetEmpty,
    // Receive side
    input  rxByte_t                     rxIn,
    output logic                        full,
    output logic [`RXBUF_CNT_WIDTH-1:0] overflowCount,
    // Host side
    input  logic                        readEn,
    output fifoEntry_t                  rdEntry,
    output logic                        empty,
    output logic [`RXBUF_CNT_WIDTH-1:0] goodFrames,
    output logic [`RXBUF_CNT_WIDTH-1:0] abortFrames
);

    logic       push;
    fifoEntry_t pushEntry;
    logic       pop;

    // Tagging and overflow handling on WClk
    rxFrameCtrl u_ctrl (
        .WClk         (WClk),
        .PresetEmpty  (PresetEmpty),
        .rxIn         (rxIn),
        .full         (full),
        .push         (push),
        .pushEntry    (pushEntry),
        .overflowCount(overflowCount)
    );

    // Clock crossing
    asyncFifo u_fifo (
        .WClk       (WClk),
        .RClk       (RClk),
        .PresetEmpty(PresetEmpty),
        .push       (push),
        .pushEntry  (pushEntry),
        .full       (full),
        .readEn     (readEn),
        .empty      (empty),
        .pop        (pop),
        .rdEntry    (rdEntry)
    );

    // Frame counts on RClk
    frameStats u_stats (
        .RClk       (RClk),
        .PresetEmpty(PresetEmpty),
        .pop        (pop),
        .rdEntry    (rdEntry),
        .goodFrames (goodFrames),
        .abortFrames(abortFrames)
    );

endmodule

//--- tests/tbUtil.svh
/*
 * Testbench helpers
 * Galois LFSR random source, value check and failure stop
 */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ========================================
// Random source
// ========================================

// Taps for x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LfsrTaps = 32'h8020_0003;
logic [31:0] lfsrState = 32'h25de;

// Returns n fresh bits, one LFSR step per bit
function automatic int unsigned randBits(input int unsigned n);
    int unsigned value;
    logic        outBit;
    value = 0;
    for (int unsigned i = 0; i < n; i++) begin
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ LfsrTaps;
        end
        value = (value << 1) | 32'(outBit);
    end
    return value;
endfunction

// ========================================
// Checks
// ========================================

// Reason first, then the verdict
task automatic abortRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
endtask

// Compare one observed value with its expected value
task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        abortRun($sformatf("Mismatch at %0t: %s is 0x%0h, expected 0x%0h",
                           $time, name, got, exp));
    end
endtask

`endif

//--- tests/tbRxFrameBuffer.sv
/*
 * Receive frame buffer testbench
 * Random frames on WClk, random reads on RClk, checked against a queue model
 */
`timescale 1ns/1ps
`include "rxbuf_cfg.svh"

module tbRxFrameBuffer import rxBufPkg::*; ();

    // 400 frames of up to 30 WClk cycles, twice over, 4 ns each
    localparam int unsigned WatchdogNs = 400 * 30 * 2 * 4;

    logic                        WClk;
    logic                        RClk;
    logic                        PresetEmpty;
    rxByte_t                     rxIn;
    logic                        readEn;
    logic                        full;
    logic                        empty;
    fifoEntry_t                  rdEntry;
    logic [`RXBUF_CNT_WIDTH-1:0] overflowCount;
    logic [`RXBUF_CNT_WIDTH-1:0] goodFrames;
    logic [`RXBUF_CNT_WIDTH-1:0] abortFrames;

    // Model state
    fifoEntry_t  modelQ[$];
    fifoEntry_t  newEntry;
    fifoEntry_t  expEntry;
    ctrlState_t  mState;
    logic        mPending;
    int unsigned mDrops;
    int unsigned mGood;
    int unsigned mAbort;
    // Read pattern, 0 held low, 1 random, 2 held high
    int unsigned readMode;
    int unsigned stallLeft;
    logic        depthCheckOn;

    `include "tbUtil.svh"

    rxFrameBuffer u_dut (
        .WClk         (WClk),
        .RClk         (RClk),
        .PresetEmpty  (PresetEmpty),
        .rxIn         (rxIn),
        .full         (full),
        .overflowCount(overflowCount),
        .readEn       (readEn),
        .rdEntry      (rdEntry),
        .empty        (empty),
        .goodFrames   (goodFrames),
        .abortFrames  (abortFrames)
    );

    // ========================================
    // Clocks and watchdog
    // ========================================

    // Edges never coincide, WClk rises at 4k+2 and RClk at 6k+3
    initial begin
        WClk = 1'b0;
        forever #2 WClk = ~WClk;
    end

    initial begin
        RClk = 1'b0;
        forever #3 RClk = ~RClk;
    end

    initial begin
        #(WatchdogNs);
        abortRun("Timeout: the test did not finish within the time limit");
    end

    // ========================================
    // Model
    // ========================================

    // Write side, sampled mid-cycle for the coming WClk edge
    always @(negedge WClk) begin
        if (PresetEmpty) begin
            modelQ.delete();
            mState   = StIdle;
            mPending = 1'b0;
            mDrops   = 0;
        end else begin
            if (depthCheckOn && full) begin
                checkEq("model depth at full", 32'(modelQ.size()), 32'd16);
            end
            if (mPending) begin
                // Marker on the first free slot, byte of this edge lost
                if (!full) begin
                    newEntry.kind = KindAbort;
                    newEntry.data = '0;
                    modelQ.push_back(newEntry);
                    mPending = 1'b0;
                end
                if (rxIn.valid && mState == StDiscard && rxIn.eof) begin
                    mState = StIdle;
                end else if (rxIn.valid) begin
                    mDrops++;
                end
            end else if (rxIn.valid && mState == StDiscard) begin
                if (rxIn.eof) begin
                    mState = StIdle;
                end else begin
                    mDrops++;
                end
            end else if (rxIn.valid && (mState == StRecv || rxIn.sof)) begin
                if (full) begin
                    // Marker only when part of the frame is stored
                    mDrops++;
                    mPending = (mState == StRecv);
                    mState   = rxIn.eof ? StIdle : StDiscard;
                end else begin
                    newEntry.kind = rxIn.eof ? KindEnd : KindData;
                    newEntry.data = rxIn.data;
                    modelQ.push_back(newEntry);
                    mState = rxIn.eof ? StIdle : StRecv;
                end
            end
        end
    end

    // Read side, the pop happens at the coming RClk edge
    always @(negedge RClk) begin
        if (PresetEmpty) begin
            mGood  = 0;
            mAbort = 0;
        end else if (readEn && !empty) begin
            if (modelQ.size() == 0) begin
                abortRun("The DUT delivered an entry that the model never queued");
            end else begin
                expEntry = modelQ.pop_front();
                checkEq("rdEntry.kind", 32'(rdEntry.kind), 32'(expEntry.kind));
                // Abort marker carries no data
                if (expEntry.kind != KindAbort) begin
                    checkEq("rdEntry.data", 32'(rdEntry.data), 32'(expEntry.data));
                end
                if (expEntry.kind == KindEnd) begin
                    mGood++;
                end else if (expEntry.kind == KindAbort) begin
                    mAbort++;
                end
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    // Host reads with random duty and occasional long stalls
    always @(posedge RClk) begin
        #1;
        if (readMode == 0) begin
            readEn = 1'b0;
        end else if (readMode == 2) begin
            readEn = 1'b1;
        end else if (stallLeft != 0) begin
            stallLeft--;
            readEn = 1'b0;
        end else if (randBits(6) == 0) begin
            stallLeft = 20 + randBits(5);
            readEn    = 1'b0;
        end else begin
            readEn = (randBits(2) != 0);
        end
    end

    task automatic driveByte(input rxByte_t b);
        @(posedge WClk);
        #1;
        rxIn = b;
    endtask

    task automatic sendFrame(input int unsigned len, input bit gaps);
        rxByte_t b;
        for (int unsigned i = 0; i < len; i++) begin
            // Idle cycles inside the frame
            if (gaps && randBits(1) == 0) begin
                repeat (randBits(2) + 1) driveByte('0);
            end
            b.valid = 1'b1;
            b.sof   = (i == 0);
            b.eof   = (i == len - 1);
            b.data  = `RXBUF_DATA_WIDTH'(randBits(`RXBUF_DATA_WIDTH));
            driveByte(b);
        end
    endtask

    // Frames of 1 to 20 bytes with random spacing
    task automatic sendFrames(input int unsigned count);
        for (int unsigned n = 0; n < count; n++) begin
            sendFrame(1 + randBits(5) % 20, 1'b1);
            repeat (randBits(2)) driveByte('0);
        end
    endtask

    // 16 WClk cycles of reset, then all flags and counters cleared
    task automatic applyReset();
        @(posedge WClk);
        #1;
        PresetEmpty = 1'b1;
        repeat (16) @(posedge WClk);
        #1;
        PresetEmpty = 1'b0;
        @(negedge WClk);
        checkEq("empty", 32'(empty), 32'd1);
        checkEq("full", 32'(full), 32'd0);
        checkEq("overflowCount", 32'(overflowCount), 32'd0);
        checkEq("goodFrames", 32'(goodFrames), 32'd0);
        checkEq("abortFrames", 32'(abortFrames), 32'd0);
    endtask

    // Inputs idle, read everything, then compare flags and counters
    task automatic drainAndCheck();
        driveByte('0);
        repeat (2) @(negedge WClk);
        readMode = 2;
        @(negedge RClk);
        while (modelQ.size() != 0 || mPending) begin
            @(negedge RClk);
        end
        @(negedge RClk);
        checkEq("empty", 32'(empty), 32'd1);
        checkEq("full", 32'(full), 32'd0);
        checkEq("overflowCount", 32'(overflowCount), mDrops);
        checkEq("goodFrames", 32'(goodFrames), mGood);
        checkEq("abortFrames", 32'(abortFrames), mAbort);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        PresetEmpty  = 1'b1;
        rxIn         = '0;
        readEn       = 1'b0;
        readMode     = 0;
        stallLeft    = 0;
        depthCheckOn = 1'b0;
        applyReset();

        // Random traffic
        readMode = 1;
        sendFrames(150);
        drainAndCheck();

        // Reads held off, FIFO fills to 16 then overflows
        readMode = 0;
        repeat (2) @(posedge RClk);
        depthCheckOn = 1'b1;
        repeat (3) sendFrame(12, 1'b0);
        driveByte('0);
        @(negedge WClk);
        checkEq("full", 32'(full), 32'd1);
        checkEq("model depth", 32'(modelQ.size()), 32'd16);
        depthCheckOn = 1'b0;
        drainAndCheck();

        readMode = 1;
        sendFrames(100);
        drainAndCheck();

        // Reset in the middle of a frame with entries stored
        readMode = 0;
        fork
            sendFrame(20, 1'b1);
            begin
                repeat (8) @(posedge WClk);
                applyReset();
            end
        join
        readMode = 1;
        sendFrames(5);
        drainAndCheck();

        $display("TB PASSED");
        $finish;
    end

endmodule

//--- src.f
+incdir+design
+incdir+tests
design/rxBufPkg.sv
design/grayCounter.sv
design/asyncFifo.sv
design/rxFrameCtrl.sv
design/frameStats.sv
design/rxFrameBuffer.sv
tests/tbRxFrameBuffer.sv

//--- Makefile
# Verilator build and run of the receive frame buffer testbench

SIM      := verilator
TOP      := tbRxFrameBuffer
FILELIST := src.f
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
OBJDIR   := obj_dir
LOG      := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard design/*.svh tests/*.svh)
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass or fail comes from the log
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
